/* hw/motion_cfg.svh */
`ifndef MOTION_CFG_SVH
`define MOTION_CFG_SVH

// packet layout as sent by the sensor
`define MW_PKT_SIZE 11
`define MW_PKT_NUM 4

// one frame is a whole group of packets
`define MW_FRAME_BYTES 44

// header, function and checksum removed
`define MW_PAYLOAD_BYTES 32

// byte offsets inside one packet
`define MW_HDR_POS 0
`define MW_FUNC_POS 1
`define MW_SUM_POS 10

// acceleration sits at the start of packet 0 data
`define MW_ACCEL_FIRST 0

// 128 entries, room for almost three frames
`define MW_FIFO_DEPTH_LOG2 7

// squared magnitude of 1 g
`define MW_G_LEVEL 32'h0040_0000

// band around 1 g that counts as quiet
`define MW_G_MARGIN 32'h0010_0000

`endif

/* hw/frame_pkg.sv */
`default_nettype none
`include "motion_cfg.svh"

package frame_pkg;

	// one byte of the sensor stream
	typedef logic [7:0] byte_t;

	// fifo fill count, one bit wider than the pointers
	typedef logic [`MW_FIFO_DEPTH_LOG2:0] fifo_level_t;

	// byte position inside a frame, 0 to 43
	typedef logic [$clog2(`MW_FRAME_BYTES)-1:0] frame_pos_t;

	// payload byte index, 0 to 31
	typedef logic [$clog2(`MW_PAYLOAD_BYTES)-1:0] pay_idx_t;

	// payload byte leaving the parser
	typedef struct packed {
		logic     vld;
		byte_t    data;
		pay_idx_t idx;
		// set on the final payload byte of a frame
		logic     last;
	} pay_beat_t;

	// finished window, first payload byte in the top bits
	typedef struct packed {
		logic [`MW_PAYLOAD_BYTES*8-1:0] payload;
		logic                           energy;
	} window_word_t;

endpackage

`default_nettype wire

/* hw/motion_pkg.sv */
`default_nettype none

package motion_pkg;

	// raw sample, little endian on the wire
	typedef logic signed [15:0] sample_t;

	// absolute value
	// unsigned so that -32768 maps to 32768
	typedef logic [15:0] mag_t;

	// three axis magnitudes of one packet
	typedef struct packed {
		mag_t x;
		mag_t y;
		mag_t z;
	} accel_t;

	// square of one magnitude, at most 2**30
	typedef logic [31:0] square_t;

	// sum of three squares
	// two spare bits so no carry is lost
	typedef logic [33:0] energy_sum_t;

endpackage

`default_nettype wire

/* hw/byte_fifo.sv */
`timescale 1ns/1ns
`default_nettype none
`include "motion_cfg.svh"

module byte_fifo (
	input  wire                    clk_50m,
	input  wire                    sys_rst_n,
	input  wire frame_pkg::byte_t  wr_data_i,
	input  wire                    wr_en_i,
	input  wire                    rd_en_i,
	output frame_pkg::byte_t       rd_data_o,
	output frame_pkg::fifo_level_t level_o
);

	localparam int DEPTH = 1 << `MW_FIFO_DEPTH_LOG2;

	typedef logic [`MW_FIFO_DEPTH_LOG2-1:0] ptr_t;

	// storage
	frame_pkg::byte_t mem [DEPTH];

	ptr_t wr_ptr;
	ptr_t rd_ptr;

	logic full;
	logic empty;
	logic do_wr;
	logic do_rd;

	assign full = (level_o == frame_pkg::fifo_level_t'(DEPTH));
	assign empty = (level_o == '0);

	// write into a full fifo is dropped
	assign do_wr = wr_en_i && !full;
	// read on empty is ignored
	assign do_rd = rd_en_i && !empty;

	// write side
	always_ff @(posedge clk_50m)
	begin
		if (do_wr)
		begin
			mem[wr_ptr] <= wr_data_i;
		end
	end

	// registered read data, valid the cycle after rd_en
	always_ff @(posedge clk_50m)
	begin
		if (do_rd)
		begin
			rd_data_o <= mem[rd_ptr];
		end
	end

	// pointers wrap naturally at depth
	always_ff @(posedge clk_50m)
	begin
		if (!sys_rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// fill level follows writes and reads
	always_ff @(posedge clk_50m)
	begin
		if (!sys_rst_n)
		begin
			level_o <= '0;
		end
		else
		begin
			case ({do_wr, do_rd})
				2'b10: level_o <= level_o + 1'b1;
				2'b01: level_o <= level_o - 1'b1;
				default: level_o <= level_o;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/frame_parser.sv */
`timescale 1ns/1ns
`default_nettype none
`include "motion_cfg.svh"

module frame_parser (
	input  wire                        clk_50m,
	input  wire                        sys_rst_n,
	input  wire frame_pkg::fifo_level_t level_i,
	input  wire frame_pkg::byte_t      rd_data_i,
	output logic                       rd_en_o,
	output frame_pkg::pay_beat_t       beat_o
);

	typedef enum logic [0:0] {
		ST_IDLE,
		ST_BURST
	} state_t;

	typedef logic [$clog2(`MW_PKT_SIZE)-1:0] offset_t;
	typedef logic [$clog2(`MW_PKT_NUM)-1:0] packet_t;

	state_t state;

	// read side position
	frame_pkg::frame_pos_t rd_cnt;
	offset_t rd_off;
	packet_t rd_pkt;

	// position delayed to line up with rd_data_i
	logic pos_vld_q;
	offset_t off_q;
	packet_t pkt_q;

	logic keep;
	frame_pkg::pay_idx_t pay_idx;

	// burst control, 44 back to back reads
	always_ff @(posedge clk_50m)
	begin
		if (!sys_rst_n)
		begin
			state <= ST_IDLE;
			rd_en_o <= 1'b0;
			rd_cnt <= '0;
			rd_off <= '0;
			rd_pkt <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					rd_cnt <= '0;
					rd_off <= '0;
					rd_pkt <= '0;
					// whole frame stored, start reading
					if (level_i >= frame_pkg::fifo_level_t'(`MW_FRAME_BYTES))
					begin
						state <= ST_BURST;
						rd_en_o <= 1'b1;
					end
				end
				ST_BURST:
				begin
					rd_cnt <= rd_cnt + 1'b1;
					// packet and offset move with the read counter
					if (rd_off == offset_t'(`MW_PKT_SIZE - 1))
					begin
						rd_off <= '0;
						rd_pkt <= rd_pkt + 1'b1;
					end
					else
					begin
						rd_off <= rd_off + 1'b1;
					end
					if (rd_cnt == frame_pkg::frame_pos_t'(`MW_FRAME_BYTES - 1))
					begin
						state <= ST_IDLE;
						rd_en_o <= 1'b0;
					end
				end
				default:
				begin
					state <= ST_IDLE;
					rd_en_o <= 1'b0;
				end
			endcase
		end
	end

	// fifo data shows up one cycle after the read
	always_ff @(posedge clk_50m)
	begin
		off_q <= rd_off;
		pkt_q <= rd_pkt;
		if (!sys_rst_n)
			pos_vld_q <= 1'b0;
		else
			pos_vld_q <= rd_en_o;
	end

	// drop header, function and checksum
	assign keep = pos_vld_q
		&& (off_q != offset_t'(`MW_HDR_POS))
		&& (off_q != offset_t'(`MW_FUNC_POS))
		&& (off_q != offset_t'(`MW_SUM_POS));

	// eight data bytes per packet, starting after the function byte
	assign pay_idx = frame_pkg::pay_idx_t'(pkt_q * (`MW_PKT_SIZE - 3))
		+ frame_pkg::pay_idx_t'(off_q - offset_t'(`MW_FUNC_POS + 1));

	// registered beat
	always_ff @(posedge clk_50m)
	begin
		beat_o.data <= rd_data_i;
		beat_o.idx <= pay_idx;
		if (!sys_rst_n)
		begin
			beat_o.vld <= 1'b0;
			beat_o.last <= 1'b0;
		end
		else
		begin
			beat_o.vld <= keep;
			beat_o.last <= keep && (pay_idx == frame_pkg::pay_idx_t'(`MW_PAYLOAD_BYTES - 1));
		end
	end

endmodule

`default_nettype wire

/* hw/accel_decoder.sv */
`timescale 1ns/1ns
`default_nettype none
`include "motion_cfg.svh"

module accel_decoder (
	input  wire                      clk_50m,
	input  wire                      sys_rst_n,
	input  wire frame_pkg::pay_beat_t beat_i,
	output motion_pkg::accel_t       accel_o,
	output logic                     accel_vld_o
);

	// x, y and z, two bytes each
	localparam int N_BYTES = 6;

	frame_pkg::byte_t samp_b [N_BYTES];

	frame_pkg::pay_idx_t rel;
	logic in_range;

	motion_pkg::sample_t raw_x;
	motion_pkg::sample_t raw_y;
	motion_pkg::sample_t raw_z;

	// two's complement magnitude
	// 16 bit result keeps 32768 exact
	function automatic motion_pkg::mag_t abs_mag(input motion_pkg::sample_t s);
		motion_pkg::mag_t m;
		m = motion_pkg::mag_t'(s);
		if (s[15])
			m = ~m + 1'b1;
		return m;
	endfunction

	// index relative to the first sample byte
	assign rel = beat_i.idx - frame_pkg::pay_idx_t'(`MW_ACCEL_FIRST);
	assign in_range = beat_i.vld && (rel < frame_pkg::pay_idx_t'(N_BYTES));

	// capture sample bytes in payload order
	always_ff @(posedge clk_50m)
	begin
		if (in_range)
		begin
			samp_b[rel[2:0]] <= beat_i.data;
		end
	end

	// strobe once the sixth byte is in
	always_ff @(posedge clk_50m)
	begin
		if (!sys_rst_n)
			accel_vld_o <= 1'b0;
		else
			accel_vld_o <= in_range && (rel == frame_pkg::pay_idx_t'(N_BYTES - 1));
	end

	// low byte first on the wire
	assign raw_x = motion_pkg::sample_t'({samp_b[1], samp_b[0]});
	assign raw_y = motion_pkg::sample_t'({samp_b[3], samp_b[2]});
	assign raw_z = motion_pkg::sample_t'({samp_b[5], samp_b[4]});

	assign accel_o.x = abs_mag(raw_x);
	assign accel_o.y = abs_mag(raw_y);
	assign accel_o.z = abs_mag(raw_z);

endmodule

`default_nettype wire

/* hw/energy_detector.sv */
`timescale 1ns/1ns
`default_nettype none
`include "motion_cfg.svh"

module energy_detector (
	input  wire                     clk_50m,
	input  wire                     sys_rst_n,
	input  wire motion_pkg::accel_t accel_i,
	input  wire                     accel_vld_i,
	output logic                    flag_o,
	output logic                    flag_vld_o
);

	// quiet band is 0x30_0000 to 0x50_0000, both ends excluded
	localparam motion_pkg::energy_sum_t E_HI =
		motion_pkg::energy_sum_t'(`MW_G_LEVEL) + motion_pkg::energy_sum_t'(`MW_G_MARGIN);
	localparam motion_pkg::energy_sum_t E_LO =
		motion_pkg::energy_sum_t'(`MW_G_LEVEL) - motion_pkg::energy_sum_t'(`MW_G_MARGIN);

	motion_pkg::square_t sq_x;
	motion_pkg::square_t sq_y;
	motion_pkg::square_t sq_z;

	motion_pkg::energy_sum_t sum_d;
	motion_pkg::energy_sum_t sum_q;

	// full width squares
	assign sq_x = motion_pkg::square_t'(accel_i.x) * motion_pkg::square_t'(accel_i.x);
	assign sq_y = motion_pkg::square_t'(accel_i.y) * motion_pkg::square_t'(accel_i.y);
	assign sq_z = motion_pkg::square_t'(accel_i.z) * motion_pkg::square_t'(accel_i.z);

	// widened before adding so carries survive
	assign sum_d = motion_pkg::energy_sum_t'(sq_x)
		+ motion_pkg::energy_sum_t'(sq_y)
		+ motion_pkg::energy_sum_t'(sq_z);

	// sum held until the next packet
	always_ff @(posedge clk_50m)
	begin
		if (accel_vld_i)
			sum_q <= sum_d;
	end

	always_ff @(posedge clk_50m)
	begin
		if (!sys_rst_n)
			flag_vld_o <= 1'b0;
		else
			flag_vld_o <= accel_vld_i;
	end

	// movement when outside the band around 1 g
	assign flag_o = (sum_q >= E_HI) || (sum_q <= E_LO);

endmodule

`default_nettype wire

/* hw/window_packer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "motion_cfg.svh"

module window_packer (
	input  wire                      clk_50m,
	input  wire                      sys_rst_n,
	input  wire frame_pkg::pay_beat_t beat_i,
	input  wire                      flag_i,
	input  wire                      flag_vld_i,
	output frame_pkg::window_word_t  win_o,
	output logic                     win_vld_o
);

	localparam int PAY_W = `MW_PAYLOAD_BYTES * 8;

	// payload shift register, oldest byte moves to the top
	logic [PAY_W-1:0] pay_q;

	// energy flag of the frame being packed
	logic flag_q;

	// one byte per valid beat
	always_ff @(posedge clk_50m)
	begin
		if (beat_i.vld)
		begin
			pay_q <= {pay_q[PAY_W-9:0], beat_i.data};
		end
	end

	// flag comes in early, around payload byte 8
	always_ff @(posedge clk_50m)
	begin
		if (!sys_rst_n)
			flag_q <= 1'b0;
		else if (flag_vld_i)
			flag_q <= flag_i;
	end

	// word complete the cycle after the last beat
	always_ff @(posedge clk_50m)
	begin
		if (!sys_rst_n)
			win_vld_o <= 1'b0;
		else
			win_vld_o <= beat_i.vld && beat_i.last;
	end

	// after 32 shifts byte 0 sits in the top 8 bits
	assign win_o.payload = pay_q;
	assign win_o.energy = flag_q;

endmodule

`default_nettype wire

/* hw/motion_window_top.sv */
`timescale 1ns/1ns
`default_nettype none

module motion_window_top (
	input  wire                          clk_50m,
	input  wire                          sys_rst_n,
	input  wire frame_pkg::byte_t        byte_i,
	input  wire                          byte_vld_i,
	output wire frame_pkg::window_word_t win_o,
	output wire                          win_vld_o
);

	// fifo to parser
	frame_pkg::byte_t fifo_rd_data;
	frame_pkg::fifo_level_t fifo_level;
	logic fifo_rd_en;

	// payload beats fan out to decoder and packer
	frame_pkg::pay_beat_t beat;

	// sample magnitudes and energy flag
	motion_pkg::accel_t accel;
	logic accel_vld;
	logic flag;
	logic flag_vld;

	// every strobed byte goes straight in
	byte_fifo m_byte_fifo (
		.clk_50m    (clk_50m     ),
		.sys_rst_n  (sys_rst_n   ),
		.wr_data_i  (byte_i      ),
		.wr_en_i    (byte_vld_i  ),
		.rd_en_i    (fifo_rd_en  ),
		.rd_data_o  (fifo_rd_data),
		.level_o    (fifo_level  )
	);

	frame_parser m_frame_parser (
		.clk_50m    (clk_50m     ),
		.sys_rst_n  (sys_rst_n   ),
		.level_i    (fifo_level  ),
		.rd_data_i  (fifo_rd_data),
		.rd_en_o    (fifo_rd_en  ),
		.beat_o     (beat        )
	);

	accel_decoder m_accel_decoder (
		.clk_50m     (clk_50m    ),
		.sys_rst_n   (sys_rst_n  ),
		.beat_i      (beat       ),
		.accel_o     (accel      ),
		.accel_vld_o (accel_vld  )
	);

	energy_detector m_energy_detector (
		.clk_50m     (clk_50m    ),
		.sys_rst_n   (sys_rst_n  ),
		.accel_i     (accel      ),
		.accel_vld_i (accel_vld  ),
		.flag_o      (flag       ),
		.flag_vld_o  (flag_vld   )
	);

	window_packer m_window_packer (
		.clk_50m     (clk_50m    ),
		.sys_rst_n   (sys_rst_n  ),
		.beat_i      (beat       ),
		.flag_i      (flag       ),
		.flag_vld_i  (flag_vld   ),
		.win_o       (win_o      ),
		.win_vld_o   (win_vld_o  )
	);

endmodule

`default_nettype wire

/* verif/motion_window_props.sv */
`timescale 1ns/1ns
`default_nettype none

module motion_window_props (
	input wire                         clk_50m,
	input wire                         sys_rst_n,
	input wire                         rd_en_i,
	input wire frame_pkg::fifo_level_t level_i,
	input wire                         win_vld_i
);

	// one word per frame, frames are 44 reads apart
	property win_single_pulse;
		@(posedge clk_50m) disable iff (!sys_rst_n)
		win_vld_i |=> !win_vld_i;
	endproperty

	// a burst only starts on a full frame
	property no_read_when_empty;
		@(posedge clk_50m) disable iff (!sys_rst_n)
		rd_en_i |-> (level_i != '0);
	endproperty

	// output pulse cleared by reset
	property win_quiet_in_reset;
		@(posedge clk_50m)
		!sys_rst_n |=> !win_vld_i;
	endproperty

	assert property (win_single_pulse)
		else $error("win_vld_o high on two consecutive cycles");

	assert property (no_read_when_empty)
		else $error("fifo read while level is zero");

	assert property (win_quiet_in_reset)
		else $error("win_vld_o high during reset");

endmodule

bind motion_window_top motion_window_props m_props (
	.clk_50m   (clk_50m   ),
	.sys_rst_n (sys_rst_n ),
	.rd_en_i   (fifo_rd_en),
	.level_i   (fifo_level),
	.win_vld_i (win_vld_o )
);

`default_nettype wire

/* verif/motion_window_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "motion_cfg.svh"

module motion_window_tb;

	localparam int FRAME_BYTES = `MW_FRAME_BYTES;
	localparam int PAY_BYTES = `MW_PAYLOAD_BYTES;
	localparam int PAY_BITS = PAY_BYTES * 8;
	// ten frames over all tests, roughly 150 cycles each
	localparam int TOTAL_FRAMES = 10;
	localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * 150 + 20;
	// 44 reads plus pipeline after the last byte goes in
	localparam int WORD_LIMIT = 100;
	localparam int SLOW_LIMIT = 60;

	logic clk_50m;
	logic sys_rst_n;
	frame_pkg::byte_t byte_i;
	logic byte_vld_i;
	wire frame_pkg::window_word_t win_o;
	wire win_vld_o;

	integer seed = 32'h1489_8d29;
	int err_cnt;
	int chk_cnt;

	// payload of the frame under construction, byte 0 first
	logic [7:0] pay_buf [PAY_BYTES];
	// same frame with header, function and checksum bytes
	logic [7:0] frame_buf [FRAME_BYTES];

	frame_pkg::window_word_t exp_q [$];
	frame_pkg::window_word_t got_q [$];
	frame_pkg::window_word_t last_word;

	motion_window_top DUT (
		.clk_50m    (clk_50m   ),
		.sys_rst_n  (sys_rst_n ),
		.byte_i     (byte_i    ),
		.byte_vld_i (byte_vld_i),
		.win_o      (win_o     ),
		.win_vld_o  (win_vld_o )
	);

	// 20 ns period
	initial
	begin
		clk_50m = 1'b0;
		forever #10 clk_50m = ~clk_50m;
	end

	// collect every finished word, sampled on the rising edge
	always @(posedge clk_50m)
	begin
		if (sys_rst_n && win_vld_o)
			got_q.push_back(win_o);
	end

	// hard stop if something hangs
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_50m);
		$display("watchdog expired after %0d cycles, %0d errors so far", WATCHDOG_CYCLES, err_cnt);
		$display("Errors found");
		$finish;
	end

	task automatic check_value(input string name, input logic [256:0] expected,
		input logic [256:0] actual);
		chk_cnt++;
		if (expected !== actual)
		begin
			err_cnt++;
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	function automatic logic [7:0] random_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// expected word straight from the frame rules
	function automatic frame_pkg::window_word_t ref_word(input logic signed [15:0] x,
		input logic signed [15:0] y, input logic signed [15:0] z);
		frame_pkg::window_word_t w;
		longint ax;
		longint ay;
		longint az;
		longint sum;
		int i;
		ax = longint'(x);
		ay = longint'(y);
		az = longint'(z);
		// magnitudes, -32768 becomes 32768
		if (ax < 0)
			ax = -ax;
		if (ay < 0)
			ay = -ay;
		if (az < 0)
			az = -az;
		sum = ax * ax + ay * ay + az * az;
		for (i = 0; i < PAY_BYTES; i++)
			w.payload[PAY_BITS-1-8*i -: 8] = pay_buf[i];
		// outside the quiet band on either side
		w.energy = (sum >= longint'(`MW_G_LEVEL) + longint'(`MW_G_MARGIN))
			|| (sum <= longint'(`MW_G_LEVEL) - longint'(`MW_G_MARGIN));
		return w;
	endfunction

	// random filler, samples little endian at the front
	task automatic build_frame(input logic signed [15:0] x, input logic signed [15:0] y,
		input logic signed [15:0] z);
		int i;
		for (i = 0; i < PAY_BYTES; i++)
			pay_buf[i] = random_byte();
		pay_buf[`MW_ACCEL_FIRST + 0] = x[7:0];
		pay_buf[`MW_ACCEL_FIRST + 1] = x[15:8];
		pay_buf[`MW_ACCEL_FIRST + 2] = y[7:0];
		pay_buf[`MW_ACCEL_FIRST + 3] = y[15:8];
		pay_buf[`MW_ACCEL_FIRST + 4] = z[7:0];
		pay_buf[`MW_ACCEL_FIRST + 5] = z[15:8];
		exp_q.push_back(ref_word(x, y, z));
	endtask

	// spread payload over four packets, fresh overhead bytes
	task automatic layout_frame(input logic [7:0] hdr);
		int p;
		int k;
		for (p = 0; p < `MW_PKT_NUM; p++)
		begin
			frame_buf[p*`MW_PKT_SIZE + `MW_HDR_POS] = hdr;
			frame_buf[p*`MW_PKT_SIZE + `MW_FUNC_POS] = random_byte();
			for (k = 0; k < 8; k++)
				frame_buf[p*`MW_PKT_SIZE + `MW_FUNC_POS + 1 + k] = pay_buf[p*8 + k];
			frame_buf[p*`MW_PKT_SIZE + `MW_SUM_POS] = random_byte();
		end
	endtask

	// piece 0 means no gaps
	// ends with the last byte still driven
	task automatic send_frame(input int piece, input int gap);
		int i;
		for (i = 0; i < FRAME_BYTES; i++)
		begin
			@(negedge clk_50m);
			byte_i = frame_buf[i];
			byte_vld_i = 1'b1;
			if (piece > 0 && i % piece == piece - 1 && i < FRAME_BYTES - 1)
			begin
				@(negedge clk_50m);
				byte_vld_i = 1'b0;
				repeat (gap - 1) @(negedge clk_50m);
			end
		end
	endtask

	task automatic drive_idle(input int cycles);
		@(negedge clk_50m);
		byte_vld_i = 1'b0;
		byte_i = '0;
		repeat (cycles - 1) @(negedge clk_50m);
	endtask

	task automatic wait_words(input string name, input int count, input int limit);
		int n;
		n = 0;
		while (got_q.size() < count && n < limit)
		begin
			@(negedge clk_50m);
			n++;
		end
		if (got_q.size() < count)
		begin
			err_cnt++;
			$display("%s: only %0d of %0d window words arrived within %0d cycles",
				name, got_q.size(), count, limit);
		end
	endtask

	// oldest received word against oldest expected word
	task automatic compare_next(input string name);
		frame_pkg::window_word_t exp;
		if (exp_q.size() == 0)
		begin
			err_cnt++;
			$display("%s: no expected word left to compare", name);
		end
		else if (got_q.size() == 0)
		begin
			exp = exp_q.pop_front();
		end
		else
		begin
			exp = exp_q.pop_front();
			last_word = got_q.pop_front();
			check_value({name, " payload"}, 257'(exp.payload), 257'(last_word.payload));
			check_value({name, " energy"}, 257'(exp.energy), 257'(last_word.energy));
		end
	endtask

	// sum exactly at 1 g, inside the band
	task automatic test_flat_frame();
		build_frame(16'sd0, 16'sd0, 16'sd2048);
		layout_frame(8'h55);
		send_frame(0, 0);
		drive_idle(1);
		wait_words("flat", 1, WORD_LIMIT);
		compare_next("flat");
		check_value("flat flag", 257'(0), 257'(last_word.energy));
		drive_idle(4);
	endtask

	task automatic test_large_samples();
		build_frame(16'sd4000, 16'sd3000, 16'sd1000);
		layout_frame(8'h55);
		send_frame(0, 0);
		drive_idle(1);
		wait_words("large", 1, WORD_LIMIT);
		compare_next("large");
		check_value("large flag", 257'(1), 257'(last_word.energy));
		drive_idle(4);
	endtask

	// small negative values, then -2048 right at 1 g
	task automatic test_negative_samples();
		build_frame(-16'sd100, -16'sd50, -16'sd10);
		layout_frame(8'h55);
		send_frame(0, 0);
		drive_idle(1);
		wait_words("negative small", 1, WORD_LIMIT);
		compare_next("negative small");
		check_value("negative small flag", 257'(1), 257'(last_word.energy));
		build_frame(-16'sd2048, 16'sd0, 16'sd0);
		layout_frame(8'h55);
		send_frame(0, 0);
		drive_idle(1);
		wait_words("negative g", 1, WORD_LIMIT);
		compare_next("negative g");
		check_value("negative g flag", 257'(0), 257'(last_word.energy));
		drive_idle(4);
	endtask

	// three frames with no idle cycle in between
	task automatic test_back_to_back();
		build_frame(16'sd1000, 16'sd1000, 16'sd1000);
		layout_frame(8'h55);
		send_frame(0, 0);
		build_frame(16'sd0, 16'sd2048, 16'sd100);
		layout_frame(8'h55);
		send_frame(0, 0);
		// -32768 has no positive twin in 16 bits
		build_frame(-16'sd32768, 16'sd5, 16'sd7);
		layout_frame(8'h55);
		send_frame(0, 0);
		drive_idle(1);
		wait_words("back to back", 3, WORD_LIMIT);
		compare_next("back to back 0");
		compare_next("back to back 1");
		compare_next("back to back 2");
		drive_idle(4);
	endtask

	// five bytes at a time, six idle cycles between pieces
	task automatic test_slow_feed();
		build_frame(16'sd1200, -16'sd1300, 16'sd700);
		layout_frame(8'h55);
		send_frame(5, 6);
		check_value("slow early words", 257'(0), 257'(got_q.size()));
		drive_idle(1);
		wait_words("slow", 1, SLOW_LIMIT);
		compare_next("slow");
		drive_idle(4);
	endtask

	// same payload, other header, function and checksum bytes
	task automatic test_overhead_ignored();
		frame_pkg::window_word_t first;
		build_frame(16'sd300, 16'sd400, -16'sd2000);
		layout_frame(8'h55);
		send_frame(0, 0);
		layout_frame(8'ha5);
		exp_q.push_back(exp_q[exp_q.size()-1]);
		send_frame(0, 0);
		drive_idle(1);
		wait_words("overhead", 2, WORD_LIMIT);
		compare_next("overhead 0");
		first = last_word;
		compare_next("overhead 1");
		check_value("overhead identical", 257'(first), 257'(last_word));
		drive_idle(4);
	endtask

	initial
	begin
		sys_rst_n = 1'b0;
		byte_i = '0;
		byte_vld_i = 1'b0;
		err_cnt = 0;
		chk_cnt = 0;
		repeat (8) @(negedge clk_50m);
		sys_rst_n = 1'b1;
		check_value("reset win_vld", 257'(0), 257'(win_vld_o));
		test_flat_frame();
		test_large_samples();
		test_negative_samples();
		test_back_to_back();
		test_slow_feed();
		test_overhead_ignored();
		// stray words would show up here
		check_value("leftover words", 257'(0), 257'(got_q.size()));
		$display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+hw
hw/frame_pkg.sv
hw/motion_pkg.sv
hw/byte_fifo.sv
hw/frame_parser.sv
hw/accel_decoder.sv
hw/energy_detector.sv
hw/window_packer.sv
hw/motion_window_top.sv
verif/motion_window_props.sv
verif/motion_window_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module motion_window_tb -f files.f
out=$(./obj_dir/Vmotion_window_tb || true)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'No errors'; then
	exit 0
fi
exit 1
